/* src.f */
rv32i_types.sv
alu.sv
cmp.sv
decode_stage.sv
execute_stage.sv
commit_stage.sv
exec_pipe_top.sv
exec_pipe_assert.sv
tb_exec_pipe.sv

/* Bender.yml */
package:
  name: exec_pipe

sources:
  - rv32i_types.sv
  - alu.sv
  - cmp.sv
  - decode_stage.sv
  - execute_stage.sv
  - commit_stage.sv
  - exec_pipe_top.sv
  - target: test
    files:
      - exec_pipe_assert.sv
      - tb_exec_pipe.sv

/* tb_exec_pipe.sv */
module tb_exec_pipe
import rv32i_types::*;
();

    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_we;
        word_t     rd_wdata;
        word_t     pc_next;
        logic      illegal;
        logic      has_wdata; // rd_wdata defined for this instruction
    } expect_t;

    logic        clk, reset, in_valid;
    logic [31:0] inst;
    word_t       pc, rs1_v, rs2_v;
    logic        out_valid, rd_we, illegal;
    reg_addr_t   rd_addr;
    word_t       rd_wdata, pc_next;

    logic [31:0] lfsr;
    expect_t     exp_q[$];
    int          checks, errors, timeouts;

    exec_pipe_top dut_i (
        .clk(clk), .reset(reset), .in_valid(in_valid), .inst(inst), .pc(pc),
        .rs1_v(rs1_v), .rs2_v(rs2_v), .out_valid(out_valid), .rd_addr(rd_addr),
        .rd_we(rd_we), .rd_wdata(rd_wdata), .pc_next(pc_next), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ####################
    // Random source
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t rand_pc();
        return {30'(take_bits(30)), 2'b00};
    endfunction

    // ####################
    // Reference model
    function automatic word_t arith_result(input logic [2:0] f3, input logic alt,
                                           input word_t x, input word_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, $signed(x) < $signed(y)};
            3'b011:  return {31'd0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic expect_t expected_result(input logic [31:0] w, input word_t p,
                                                input word_t a, input word_t b);
        expect_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      imm_i, imm_u, imm_b, imm_j;
        logic       writes, bad, take;
        e      = '0;
        f3     = w[14:12];
        f7     = w[31:25];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_u  = {w[31:12], 12'd0};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        writes = 1'b1;
        bad    = 1'b0;
        take   = 1'b0;
        e.pc_next = p + 32'd4;
        case (w[6:0])
            7'b0110111: e.rd_wdata = imm_u; // LUI
            7'b0010111: e.rd_wdata = p + imm_u; // AUIPC
            7'b1101111: begin
                e.rd_wdata = p + 32'd4;
                e.pc_next  = p + imm_j;
            end
            7'b1100111: begin
                bad        = (f3 != 3'b000);
                e.rd_wdata = p + 32'd4;
                e.pc_next  = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                writes = 1'b0;
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (take)
                    e.pc_next = p + imm_b;
            end
            7'b0010011: begin
                if (f3 == 3'b001)
                    bad = (f7 != 7'h00);
                if (f3 == 3'b101)
                    bad = (f7 != 7'h00) && (f7 != 7'h20);
                e.rd_wdata = arith_result(f3, (f3 == 3'b101) && f7[5], a, imm_i);
            end
            7'b0110011: begin
                bad = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)));
                e.rd_wdata = arith_result(f3, f7[5], a, b);
            end
            default: bad = 1'b1;
        endcase
        if (bad)
            e.pc_next = p + 32'd4;
        e.rd_addr   = w[11:7];
        e.illegal   = bad;
        e.rd_we     = writes && !bad && (w[11:7] != 5'd0);
        e.has_wdata = writes && !bad;
        return e;
    endfunction

    // ####################
    // Compare tasks
    task automatic check_word(input string what, input word_t got, input word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_reg_addr(input string what, input reg_addr_t got,
                                  input reg_addr_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (!reset && out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: out_valid with no instruction in flight", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_reg_addr("rd_addr", rd_addr, e.rd_addr);
                    check_flag("rd_we", rd_we, e.rd_we);
                    check_flag("illegal", illegal, e.illegal);
                    check_word("pc_next", pc_next, e.pc_next);
                    if (e.has_wdata)
                        check_word("rd_wdata", rd_wdata, e.rd_wdata);
                end
            end
        end
    end

    // ####################
    // Stimulus
    task automatic issue(input logic [31:0] w, input word_t p, input word_t a, input word_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        inst     <= w;
        pc       <= p;
        rs1_v    <= a;
        rs2_v    <= b;
        exp_q.push_back(expected_result(w, p, a, b));
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        int cycles;
        idle();
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d instructions never retired in test %0d", exp_q.size(), num);
            exp_q.delete();
        end
        $display("test %0d %s done, %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int          k, cycles, err0;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [11:0] imm12;
        logic [12:0] bimm;
        logic [20:0] jimm;
        logic [31:0] w;
        word_t       a, b, t;
        reset    = 1'b1;
        in_valid = 1'b0;
        inst     = '0;
        pc       = '0;
        rs1_v    = '0;
        rs2_v    = '0;
        lfsr     = 32'h50670841;
        checks   = 0;
        errors   = 0;
        timeouts = 0;

        // Test 1, reset and first retire
        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            in_valid <= (i < 15); // Junk issue while reset is held
            inst     <= take_bits(32);
            if (i == 15)
                reset <= 1'b0;
            @(negedge clk);
            check_flag("out_valid at reset", out_valid, 1'b0);
            check_flag("rd_we at reset", rd_we, 1'b0);
            check_flag("illegal at reset", illegal, 1'b0);
        end
        issue({12'(take_bits(12)), 5'd1, 3'b000, 5'd3, 7'b0010011}, rand_pc(),
              take_bits(32), take_bits(32));
        idle();
        cycles = 0;
        while (out_valid !== 1'b1 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid !== 1'b1) begin
            timeouts++;
            $display("Timeout: the first instruction never retired");
        end else if (cycles != 3) begin
            errors++;
            $display("Error at %0t: retired after %0d cycles, expected 3", $time, cycles);
        end
        finish_test(1, "reset and latency", err0);

        // Test 2, OP back to back
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            k  = take_bits(4) % 10;
            f3 = (k < 8) ? k[2:0] : ((k == 8) ? 3'b000 : 3'b101);
            f7 = (k < 8) ? 7'h00 : 7'h20;
            rd = (i % 5 == 0) ? 5'd0 : 5'(take_bits(5));
            issue({f7, 10'(take_bits(10)), f3, rd, 7'b0110011}, rand_pc(),
                  take_bits(32), take_bits(32));
        end
        finish_test(2, "OP", err0);

        // Test 3, OP-IMM, LUI and AUIPC
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            k  = take_bits(2);
            rd = 5'(take_bits(5));
            if (k < 2) begin
                f3    = 3'(take_bits(3));
                imm12 = 12'(take_bits(12));
                if (f3 == 3'b001)
                    imm12[11:5] = 7'h00;
                if (f3 == 3'b101)
                    imm12[11:5] = {1'b0, imm12[10], 5'd0}; // srai or srli
                w = {imm12, 5'(take_bits(5)), f3, rd, 7'b0010011};
            end else begin
                w = {20'(take_bits(20)), rd, (k == 2) ? 7'b0110111 : 7'b0010111};
            end
            issue(w, rand_pc(), take_bits(32), take_bits(32));
        end
        finish_test(3, "OP-IMM, LUI and AUIPC", err0);

        // Test 4, branches
        err0 = errors;
        for (int j = 0; j < 8; j++) begin
            if (j == 2 || j == 3)
                continue;
            for (int p = 0; p < 5; p++) begin
                a = {2'b00, 30'(take_bits(30))};
                b = a + 32'd1 + take_bits(8);
                case (p)
                    0: b = a;
                    2: begin
                        t = a;
                        a = b;
                        b = t;
                    end
                    3: a[31] = 1'b1; // Signed smaller, unsigned larger
                    4: b[31] = 1'b1;
                    default: ;
                endcase
                bimm = {12'(take_bits(12)), 1'b0};
                w = {bimm[12], bimm[10:5], 10'(take_bits(10)), j[2:0], bimm[4:1], bimm[11],
                     7'b1100011};
                issue(w, rand_pc(), a, b);
            end
        end
        finish_test(4, "branches", err0);

        // Test 5, JAL and JALR
        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            rd = 5'(take_bits(5));
            if (i % 2 == 0) begin
                jimm = {20'(take_bits(20)), 1'b0};
                w = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
            end else begin
                w = {17'(take_bits(17)), 3'b000, rd, 7'b1100111};
            end
            issue(w, rand_pc(), take_bits(32), take_bits(32));
        end
        finish_test(5, "JAL and JALR", err0);

        // Test 6, illegal words mixed with legal ones
        err0 = errors;
        for (int i = 0; i < 45; i++) begin
            rd = 5'(take_bits(5));
            case (i % 3)
                0: w = take_bits(32);
                1: begin
                    case (take_bits(2))
                        0: w = {1'b1, 19'(take_bits(19)), rd, 7'b0110011};
                        1: w = {1'b1, 16'(take_bits(16)), 3'b001, rd, 7'b0010011};
                        2: w = {17'(take_bits(17)), 2'b01, 1'(take_bits(1)), rd, 7'b1100011};
                        default: w = {17'(take_bits(17)), 2'(take_bits(2)), 1'b1, rd,
                                      7'b1100111};
                    endcase
                end
                default: w = {17'(take_bits(17)), 3'b000, rd, 7'b0010011};
            endcase
            issue(w, rand_pc(), take_bits(32), take_bits(32));
        end
        finish_test(6, "illegal words", err0);

        errors += dut_i.assert_i.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* exec_pipe_assert.sv */
module exec_pipe_assert
import rv32i_types::*;
(
    input logic      clk,
    input logic      reset,
    input logic      in_valid,
    input logic      out_valid,
    input logic      rd_we,
    input logic      illegal,
    input reg_addr_t rd_addr
);

    int fail_count = 0;

    // ####################
    // Fixed latency, both directions
    issue_to_retire: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !reset) |-> ##3 out_valid) // Strobe at the release edge is dropped
        else begin
            $error("out_valid missing 3 cycles after in_valid");
            fail_count++;
        end

    retire_from_issue: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, 3))
        else begin
            $error("out_valid without in_valid 3 cycles earlier");
            fail_count++;
        end

    reset_clears: assert property (@(posedge clk)
        reset |=> (!out_valid && !rd_we && !illegal))
        else begin
            $error("outputs not cleared by reset");
            fail_count++;
        end

    write_needs_rd: assert property (@(posedge clk) disable iff (reset)
        rd_we |-> (out_valid && rd_addr != 5'd0)) // Never x0
        else begin
            $error("rd_we without out_valid or with rd x0");
            fail_count++;
        end

endmodule

bind exec_pipe_top exec_pipe_assert assert_i (
    .clk(clk), .reset(reset), .in_valid(in_valid), .out_valid(out_valid),
    .rd_we(rd_we), .illegal(illegal), .rd_addr(rd_addr)
);

/* exec_pipe_top.sv */
module exec_pipe_top
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] inst,
    input  word_t       pc,
    input  word_t       rs1_v,
    input  word_t       rs2_v,
    output logic        out_valid,
    output reg_addr_t   rd_addr,
    output logic        rd_we,
    output word_t       rd_wdata,
    output word_t       pc_next,
    output logic        illegal
);

    // ####################
    // Decode to execute
    logic           id_valid, id_rd_we, id_illegal;
    word_t          id_pc, id_rs1_v, id_rs2_v, id_u_imm, id_i_imm, id_pc_target;
    reg_addr_t      id_rd_addr;
    alu_ops_t       id_aluop;
    branch_funct3_t id_cmpop;
    alu_m1_sel_t    id_alu_m1_sel;
    alu_m2_sel_t    id_alu_m2_sel;
    cmp_sel_t       id_cmp_sel;
    wb_sel_t        id_wb_sel;
    jump_kind_t     id_jump_kind;

    // Execute to commit
    logic           ex_valid, ex_br_en, ex_rd_we, ex_illegal;
    word_t          ex_pc, ex_alu_out, ex_u_imm, ex_pc_target;
    reg_addr_t      ex_rd_addr;
    wb_sel_t        ex_wb_sel;
    jump_kind_t     ex_jump_kind;

    decode_stage decode_i (
        .clk(clk), .reset(reset), .in_valid(in_valid), .inst(inst),
        .pc(pc), .rs1_v(rs1_v), .rs2_v(rs2_v),
        .id_valid(id_valid), .id_pc(id_pc), .id_rs1_v(id_rs1_v), .id_rs2_v(id_rs2_v),
        .id_u_imm(id_u_imm), .id_i_imm(id_i_imm), .id_pc_target(id_pc_target),
        .id_rd_addr(id_rd_addr), .id_rd_we(id_rd_we), .id_illegal(id_illegal),
        .id_aluop(id_aluop), .id_cmpop(id_cmpop), .id_alu_m1_sel(id_alu_m1_sel),
        .id_alu_m2_sel(id_alu_m2_sel), .id_cmp_sel(id_cmp_sel), .id_wb_sel(id_wb_sel),
        .id_jump_kind(id_jump_kind)
    );

    execute_stage execute_i (
        .clk(clk), .reset(reset),
        .id_valid(id_valid), .id_pc(id_pc), .id_rs1_v(id_rs1_v), .id_rs2_v(id_rs2_v),
        .id_u_imm(id_u_imm), .id_i_imm(id_i_imm), .id_pc_target(id_pc_target),
        .id_rd_addr(id_rd_addr), .id_rd_we(id_rd_we), .id_illegal(id_illegal),
        .id_aluop(id_aluop), .id_cmpop(id_cmpop), .id_alu_m1_sel(id_alu_m1_sel),
        .id_alu_m2_sel(id_alu_m2_sel), .id_cmp_sel(id_cmp_sel), .id_wb_sel(id_wb_sel),
        .id_jump_kind(id_jump_kind),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_alu_out(ex_alu_out), .ex_br_en(ex_br_en),
        .ex_u_imm(ex_u_imm), .ex_pc_target(ex_pc_target), .ex_rd_addr(ex_rd_addr),
        .ex_rd_we(ex_rd_we), .ex_illegal(ex_illegal), .ex_wb_sel(ex_wb_sel),
        .ex_jump_kind(ex_jump_kind)
    );

    commit_stage commit_i (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_alu_out(ex_alu_out), .ex_br_en(ex_br_en),
        .ex_u_imm(ex_u_imm), .ex_pc_target(ex_pc_target), .ex_rd_addr(ex_rd_addr),
        .ex_rd_we(ex_rd_we), .ex_illegal(ex_illegal), .ex_wb_sel(ex_wb_sel),
        .ex_jump_kind(ex_jump_kind),
        .out_valid(out_valid), .rd_addr(rd_addr), .rd_we(rd_we), .rd_wdata(rd_wdata),
        .pc_next(pc_next), .illegal(illegal)
    );

endmodule

/* commit_stage.sv */
module commit_stage
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ex_valid,
    input  word_t      ex_pc,
    input  word_t      ex_alu_out,
    input  logic       ex_br_en,
    input  word_t      ex_u_imm,
    input  word_t      ex_pc_target,
    input  reg_addr_t  ex_rd_addr,
    input  logic       ex_rd_we,
    input  logic       ex_illegal,
    input  wb_sel_t    ex_wb_sel,
    input  jump_kind_t ex_jump_kind,
    output logic       out_valid,
    output reg_addr_t  rd_addr,
    output logic       rd_we,
    output word_t      rd_wdata,
    output word_t      pc_next,
    output logic       illegal
);

    word_t pc4;
    word_t wdata_c;
    word_t pc_next_c;

    assign pc4 = ex_pc + 32'd4;

    // ####################
    // Write-back mux
    always_comb begin
        unique case (ex_wb_sel)
            wb_alu:   wdata_c = ex_alu_out;
            wb_cmp:   wdata_c = {31'd0, ex_br_en};
            wb_u_imm: wdata_c = ex_u_imm;
            wb_pc4:   wdata_c = pc4;
        endcase
    end

    // Next pc
    always_comb begin
        unique case (ex_jump_kind)
            jk_jal:    pc_next_c = ex_pc_target;
            jk_jalr:   pc_next_c = {ex_alu_out[31:1], 1'b0};
            jk_branch: pc_next_c = ex_br_en ? ex_pc_target : pc4;
            jk_none:   pc_next_c = pc4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rd_we     <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= ex_valid;
            rd_we     <= ex_valid & ex_rd_we;
            illegal   <= ex_valid & ex_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            rd_addr  <= ex_rd_addr;
            rd_wdata <= wdata_c;
            pc_next  <= pc_next_c;
        end
    end

endmodule

/* execute_stage.sv */
module execute_stage
import rv32i_types::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           id_valid,
    input  word_t          id_pc,
    input  word_t          id_rs1_v,
    input  word_t          id_rs2_v,
    input  word_t          id_u_imm,
    input  word_t          id_i_imm,
    input  word_t          id_pc_target,
    input  reg_addr_t      id_rd_addr,
    input  logic           id_rd_we,
    input  logic           id_illegal,
    input  alu_ops_t       id_aluop,
    input  branch_funct3_t id_cmpop,
    input  alu_m1_sel_t    id_alu_m1_sel,
    input  alu_m2_sel_t    id_alu_m2_sel,
    input  cmp_sel_t       id_cmp_sel,
    input  wb_sel_t        id_wb_sel,
    input  jump_kind_t     id_jump_kind,
    output logic           ex_valid,
    output word_t          ex_pc,
    output word_t          ex_alu_out,
    output logic           ex_br_en,
    output word_t          ex_u_imm,
    output word_t          ex_pc_target,
    output reg_addr_t      ex_rd_addr,
    output logic           ex_rd_we,
    output logic           ex_illegal,
    output wb_sel_t        ex_wb_sel,
    output jump_kind_t     ex_jump_kind
);

    word_t alu_a, alu_b, alu_out;
    word_t cmp_b;
    logic  br_en;

    // ####################
    // Operand muxes
    always_comb begin
        unique case (id_alu_m1_sel)
            rs1_out: alu_a = id_rs1_v;
            pc_out:  alu_a = id_pc;
        endcase
    end

    always_comb begin
        unique case (id_alu_m2_sel)
            rs2_out:   alu_b = id_rs2_v;
            u_imm_sel: alu_b = id_u_imm;
            i_imm_sel: alu_b = id_i_imm;
            const4:    alu_b = 32'd4;
        endcase
    end

    assign cmp_b = (id_cmp_sel == i_imm_cmp) ? id_i_imm : id_rs2_v;

    alu alu_i (.aluop(id_aluop), .a(alu_a), .b(alu_b), .aluout(alu_out));
    cmp cmp_i (.cmpop(id_cmpop), .a(id_rs1_v), .b(cmp_b), .br_en(br_en));

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid   <= 1'b0;
            ex_rd_we   <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid   <= id_valid;
            ex_rd_we   <= id_valid & id_rd_we;
            ex_illegal <= id_valid & id_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_pc        <= id_pc;
            ex_alu_out   <= alu_out;
            ex_br_en     <= br_en;
            ex_u_imm     <= id_u_imm;
            ex_pc_target <= id_pc_target;
            ex_rd_addr   <= id_rd_addr;
            ex_wb_sel    <= id_wb_sel;
            ex_jump_kind <= id_jump_kind;
        end
    end

endmodule

/* decode_stage.sv */
module decode_stage
import rv32i_types::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  logic [31:0]    inst,
    input  word_t          pc,
    input  word_t          rs1_v,
    input  word_t          rs2_v,
    output logic           id_valid,
    output word_t          id_pc,
    output word_t          id_rs1_v,
    output word_t          id_rs2_v,
    output word_t          id_u_imm,
    output word_t          id_i_imm,
    output word_t          id_pc_target,
    output reg_addr_t      id_rd_addr,
    output logic           id_rd_we,
    output logic           id_illegal,
    output alu_ops_t       id_aluop,
    output branch_funct3_t id_cmpop,
    output alu_m1_sel_t    id_alu_m1_sel,
    output alu_m2_sel_t    id_alu_m2_sel,
    output cmp_sel_t       id_cmp_sel,
    output wb_sel_t        id_wb_sel,
    output jump_kind_t     id_jump_kind
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    reg_addr_t      rd;
    word_t          i_imm, u_imm, b_imm, j_imm;
    alu_ops_t       aluop_c;
    branch_funct3_t cmpop_c;
    alu_m1_sel_t    m1_sel_c;
    alu_m2_sel_t    m2_sel_c;
    cmp_sel_t       cmp_sel_c;
    wb_sel_t        wb_sel_c;
    jump_kind_t     jump_kind_c;
    logic           writes_rd;
    logic           illegal_c;
    logic           rd_we_c;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    // ####################
    // Immediates
    assign i_imm = {{21{inst[31]}}, inst[30:20]};
    assign u_imm = {inst[31:12], 12'h000};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // ####################
    // Control decode
    always_comb begin
        aluop_c     = alu_ops_t'(funct3);
        cmpop_c     = branch_funct3_t'(funct3);
        m1_sel_c    = rs1_out;
        m2_sel_c    = rs2_out;
        cmp_sel_c   = rs2_out_cmp;
        wb_sel_c    = wb_alu;
        jump_kind_c = jk_none;
        writes_rd   = 1'b1;
        illegal_c   = 1'b0;
        case (rv32i_opcode_t'(opcode))
            op_lui: wb_sel_c = wb_u_imm;
            op_auipc: begin
                aluop_c  = alu_add;
                m1_sel_c = pc_out;
                m2_sel_c = u_imm_sel;
            end
            op_jal: begin
                aluop_c     = alu_add;
                m1_sel_c    = pc_out;
                m2_sel_c    = const4;
                wb_sel_c    = wb_pc4;
                jump_kind_c = jk_jal;
            end
            op_jalr: begin
                aluop_c     = alu_add; // rs1 + imm as target
                m2_sel_c    = i_imm_sel;
                wb_sel_c    = wb_pc4;
                jump_kind_c = jk_jalr;
                illegal_c   = (funct3 != 3'b000);
            end
            op_br: begin
                jump_kind_c = jk_branch;
                writes_rd   = 1'b0;
                illegal_c   = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            op_imm: begin
                m2_sel_c  = i_imm_sel;
                cmp_sel_c = i_imm_cmp;
                unique case (funct3)
                    3'b010: begin
                        cmpop_c  = blt;
                        wb_sel_c = wb_cmp;
                    end
                    3'b011: begin
                        cmpop_c  = bltu;
                        wb_sel_c = wb_cmp;
                    end
                    3'b001: illegal_c = (funct7 != 7'b0000000);
                    3'b101: begin
                        if (funct7 == 7'b0100000)
                            aluop_c = alu_sra;
                        else
                            illegal_c = (funct7 != 7'b0000000);
                    end
                    default: ;
                endcase
            end
            op_reg: begin
                if (funct3 == 3'b010) begin
                    cmpop_c  = blt;
                    wb_sel_c = wb_cmp;
                end else if (funct3 == 3'b011) begin
                    cmpop_c  = bltu;
                    wb_sel_c = wb_cmp;
                end
                if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000)
                        aluop_c = alu_sub;
                    else if (funct3 == 3'b101)
                        aluop_c = alu_sra;
                    else
                        illegal_c = 1'b1;
                end else if (funct7 != 7'b0000000) begin
                    illegal_c = 1'b1;
                end
            end
            default: illegal_c = 1'b1;
        endcase
        if (illegal_c)
            jump_kind_c = jk_none; // Falls through to pc + 4
    end

    assign rd_we_c = writes_rd & ~illegal_c & (rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid   <= 1'b0;
            id_rd_we   <= 1'b0;
            id_illegal <= 1'b0;
        end else begin
            id_valid   <= in_valid;
            id_rd_we   <= in_valid & rd_we_c;
            id_illegal <= in_valid & illegal_c;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            id_pc         <= pc;
            id_rs1_v      <= rs1_v;
            id_rs2_v      <= rs2_v;
            id_u_imm      <= u_imm;
            id_i_imm      <= i_imm;
            id_pc_target  <= pc + ((jump_kind_c == jk_jal) ? j_imm : b_imm);
            id_rd_addr    <= rd;
            id_aluop      <= aluop_c;
            id_cmpop      <= cmpop_c;
            id_alu_m1_sel <= m1_sel_c;
            id_alu_m2_sel <= m2_sel_c;
            id_cmp_sel    <= cmp_sel_c;
            id_wb_sel     <= wb_sel_c;
            id_jump_kind  <= jump_kind_c;
        end
    end

endmodule

/* cmp.sv */
module cmp
import rv32i_types::*;
(
    input  branch_funct3_t cmpop,
    input  word_t          a,
    input  word_t          b,
    output logic           br_en
);

    always_comb begin
        unique case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = ($signed(a) < $signed(b)); // Also slt
            bge:     br_en = ($signed(a) >= $signed(b));
            bltu:    br_en = (a < b);                   // Also sltu
            bgeu:    br_en = (a >= b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

/* alu.sv */
module alu
import rv32i_types::*;
(
    input  alu_ops_t aluop,
    input  word_t    a,
    input  word_t    b,
    output word_t    aluout
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // RV32 uses 5 bit shifts

    always_comb begin
        unique case (aluop)
            alu_add: aluout = a + b;
            alu_sll: aluout = a << shamt;
            alu_sra: aluout = word_t'($signed(a) >>> shamt);
            alu_sub: aluout = a - b;
            alu_xor: aluout = a ^ b;
            alu_srl: aluout = a >> shamt;
            alu_or:  aluout = a | b;
            alu_and: aluout = a & b;
            default: aluout = a + b;
        endcase
    end

endmodule

/* rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // ####################
    // Major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // Lines up with funct3 except sub and sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // Branch funct3, also used for slt and sltu
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // ####################
    // Datapath selects
    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alu_m1_sel_t;

    typedef enum logic [1:0] {
        rs2_out   = 2'b00,
        u_imm_sel = 2'b01,
        i_imm_sel = 2'b10,
        const4    = 2'b11
    } alu_m2_sel_t;

    typedef enum logic {
        rs2_out_cmp = 1'b0,
        i_imm_cmp   = 1'b1
    } cmp_sel_t;

    typedef enum logic [1:0] {
        wb_alu   = 2'b00,
        wb_cmp   = 2'b01,
        wb_u_imm = 2'b10,
        wb_pc4   = 2'b11
    } wb_sel_t;

    typedef enum logic [1:0] {
        jk_none   = 2'b00,
        jk_branch = 2'b01,
        jk_jal    = 2'b10,
        jk_jalr   = 2'b11
    } jump_kind_t;

endpackage
